//--- arb_pkg.sv
package arb_pkg;

   // requester count and grouping for the two-level tree
   localparam int ARB_WIDTH   = 16;
   localparam int GROUP_NUM   = 4;
   localparam int GROUP_WIDTH = ARB_WIDTH / GROUP_NUM;   // members per group

   // binary last-winner pointer inside a group arbiter
   localparam int GROUP_PTR_W = $clog2(GROUP_WIDTH);

   // one bit per requester, top request and grant
   typedef logic [ARB_WIDTH-1:0] req_vec_t;

   // one bit per group or per group member
   typedef logic [GROUP_NUM-1:0] grp_vec_t;

endpackage

//--- arb_if.sv
`timescale 1ns/1ps

// signals between the top and one group arbiter
interface arb_if
   import arb_pkg::*;
#(
   parameter int WIDTH = GROUP_WIDTH
);

   logic [WIDTH-1:0] request;      // group slice of the top request
   logic [WIDTH-1:0] grant;        // one-hot or zero
   logic             any_grant;    // some member requests
   logic             priority_en;  // root picked this group, advance pointer

   // group arbiter side
   modport arbiter (
      input  request,
      input  priority_en,
      output grant,
      output any_grant
   );

   // side that owns the requests and the root decision
   modport requester (
      output request,
      output priority_en,
      input  grant,
      input  any_grant
   );

endinterface

//--- rr_group_arbiter.sv
`timescale 1ns/1ps

// round-robin arbiter for a small group, 2 to 4 members
// pointer holds the binary index of the last winner
module rr_group_arbiter
   import arb_pkg::*;
#(
   parameter int WIDTH = GROUP_WIDTH
) (
   input  logic   clk,
   input  logic   rst_n,
   arb_if.arbiter bus
);

   logic [GROUP_PTR_W-1:0] last_ptr;   // last winner
   logic [GROUP_PTR_W-1:0] win_idx;    // binary index of current grant
   logic [WIDTH-1:0]       grant_c;

   // search starts at the member after the last winner and wraps
   always_comb begin : rotate_search
      int  idx;
      logic found;
      grant_c = '0;
      found   = 1'b0;
      idx     = 0;
      for (int off = 1; off <= WIDTH; off++) begin
         idx = (int'(last_ptr) + off) % WIDTH;
         if (!found && bus.request[idx]) begin
            grant_c[idx] = 1'b1;
            found        = 1'b1;
         end
      end
   end

   // one-hot grant back to binary for the pointer
   always_comb begin : grant_to_index
      win_idx = '0;
      for (int i = 0; i < WIDTH; i++) begin
         if (grant_c[i]) begin
            win_idx = GROUP_PTR_W'(i);
         end
      end
   end

   // pointer moves only when the root took this group
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_ptr <= '0;   // first search order 1, 2, 3, 0
      end else if (bus.priority_en) begin
         last_ptr <= win_idx;
      end
   end

   assign bus.grant     = grant_c;
   assign bus.any_grant = |grant_c;   // a member was found by the search

   // grant is one member at most
   a_grant_onehot: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(bus.grant)
   ) else $error("group grant has more than one bit set");

   // no grant without a request behind it
   a_grant_subset: assert property (
      @(posedge clk) disable iff (!rst_n)
      (bus.grant & ~bus.request) == '0
   ) else $error("group grant to a member that does not request");

   // the root sees a request exactly when the group holds one
   a_any_matches: assert property (
      @(posedge clk) disable iff (!rst_n)
      bus.any_grant == (|bus.request)
   ) else $error("group any_grant does not match its requests");

   // root only enables a group that has something to grant
   a_enable_has_grant: assert property (
      @(posedge clk) disable iff (!rst_n)
      bus.priority_en |-> (|bus.grant)
   ) else $error("priority enable on a group with no grant");

endmodule

//--- rr_thermo_arbiter.sv
`timescale 1ns/1ps

// round-robin arbiter with a thermometer-coded mask
// lowest index wins within the masked or the full request
module rr_thermo_arbiter
   import arb_pkg::*;
#(
   parameter int WIDTH = GROUP_NUM
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [WIDTH-1:0] request,
   output logic [WIDTH-1:0] grant,
   output logic             any_grant
);

   logic [WIDTH-1:0] mask;          // ones above the last winner
   logic [WIDTH-1:0] masked_req;
   logic [WIDTH-1:0] therm_req;     // ones from lowest request upward
   logic [WIDTH-1:0] therm_masked;
   logic [WIDTH-1:0] therm_sel;
   logic [WIDTH-1:0] edge_mask;
   logic [WIDTH-1:0] mask_next;

   assign masked_req = request & mask;

   // running OR from bit 0 upward gives both thermometer codes
   always_comb begin : thermo_codes
      therm_req[0]    = request[0];
      therm_masked[0] = masked_req[0];
      for (int i = 1; i < WIDTH; i++) begin
         therm_req[i]    = therm_req[i-1] | request[i];
         therm_masked[i] = therm_masked[i-1] | masked_req[i];
      end
   end

   // masked code wins if anything above the last winner requests
   assign therm_sel = therm_masked[WIDTH-1] ? therm_masked : therm_req;
   assign edge_mask = {therm_sel[WIDTH-2:0], 1'b0};
   assign grant     = therm_sel ^ edge_mask;   // keeps the lowest edge only
   assign any_grant = therm_req[WIDTH-1];

   // top bit won, so the shifted code is empty
   // all ones searches from bit 0 just as the empty mask would
   assign mask_next = (edge_mask == '0) ? '1 : edge_mask;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mask <= '1;   // start at bit 0
      end else if (any_grant) begin
         mask <= mask_next;
      end
   end

   a_grant_onehot: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(grant)
   ) else $error("root grant has more than one bit set");

   // an empty mask would hide every request from the masked search
   a_mask_nonzero: assert property (
      @(posedge clk) disable iff (!rst_n)
      mask != '0
   ) else $error("root mask is all zero");

endmodule

//--- tree_arbiter.sv
`timescale 1ns/1ps

// two-level round-robin arbiter for 16 requesters
// four group arbiters feed one thermometer root
module tree_arbiter
   import arb_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  req_vec_t request,
   output req_vec_t grant,
   output logic     any_grant
);

   grp_vec_t group_any;    // group holds at least one request
   grp_vec_t root_grant;   // one group selected by the root

   for (genvar g = 0; g < GROUP_NUM; g++) begin : grp

      arb_if #(
         .WIDTH (GROUP_WIDTH)
      ) grp_bus ();

      // requester side of the group link
      assign grp_bus.request     = request[g*GROUP_WIDTH +: GROUP_WIDTH];
      assign grp_bus.priority_en = root_grant[g];   // pointer moves only on a root win

      rr_group_arbiter #(
         .WIDTH (GROUP_WIDTH)
      ) group_arb (
         .clk   (clk),
         .rst_n (rst_n),
         .bus   (grp_bus.arbiter)
      );

      assign group_any[g] = grp_bus.any_grant;

      // only the root-selected group reaches the output
      assign grant[g*GROUP_WIDTH +: GROUP_WIDTH] =
         root_grant[g] ? grp_bus.grant : '0;

   end

   rr_thermo_arbiter #(
      .WIDTH (GROUP_NUM)
   ) root_arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .request   (group_any),
      .grant     (root_grant),
      .any_grant (any_grant)
   );

   // one requester at a time over the whole tree
   a_top_onehot: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(grant)
   ) else $error("top grant has more than one bit set");

   // any request anywhere must come out as a granted requester
   a_top_any_granted: assert property (
      @(posedge clk) disable iff (!rst_n)
      any_grant |-> ((grant & request) != '0)
   ) else $error("any_grant high but no requester is granted");

   // nothing granted while the tree is idle
   a_top_idle: assert property (
      @(posedge clk) disable iff (!rst_n)
      (request == '0) |-> (!any_grant && (grant == '0))
   ) else $error("grant or any_grant without any request");

endmodule

//--- tree_arbiter_checker.sv
`timescale 1ns/1ps

// watches the tree arbiter outputs and compares them with the expected values
// one result line per finished test, counts at the end of the run
module tree_arbiter_checker
   import arb_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  req_vec_t grant,
   input  logic     any_grant,
   input  req_vec_t exp_grant,
   input  logic     exp_any,
   input  int       test_num,
   input  logic     check_en,      // a vector is on the DUT inputs
   input  logic     end_run,       // last vector done, print the counts
   output int       mismatch_count,
   output int       failed_tests,
   output logic     report_done
);

   int active_test;      // -1 while no test is open
   int test_errors;      // mismatches in the open test
   int tests_run;
   int cycles_checked;

   initial begin
      active_test    = -1;
      test_errors    = 0;
      tests_run      = 0;
      cycles_checked = 0;
      mismatch_count = 0;
      failed_tests   = 0;
      report_done    = 1'b0;
   end

   // result line for the test that just ended
   task automatic close_test();
      if (active_test >= 0) begin
         tests_run++;
         if (test_errors == 0) begin
            $display("test %0d passed", active_test);
         end else begin
            failed_tests++;
            $display("test %0d failed with %0d mismatches", active_test, test_errors);
         end
      end
      test_errors = 0;
      active_test = -1;
   endtask

   task automatic compare_grant();
      if (grant !== exp_grant) begin
         $display("Error at %0d ns: signal grant expected %h actual %h",
                  $time, exp_grant, grant);
         test_errors++;
         mismatch_count++;
      end
   endtask

   task automatic compare_any_grant();
      if (any_grant !== exp_any) begin
         $display("Error at %0d ns: signal any_grant expected %b actual %b",
                  $time, exp_any, any_grant);
         test_errors++;
         mismatch_count++;
      end
   endtask

   // inputs change on the falling edge, so they are settled here
   always @(posedge clk) begin : compare
      if (rst_n && check_en && !report_done) begin
         if (test_num != active_test) begin
            close_test();
            active_test = test_num;   // new test starts with this vector
         end
         cycles_checked++;
         compare_grant();
         compare_any_grant();
      end
      if (end_run && !report_done) begin
         close_test();
         $display("%0d tests run, %0d failed, %0d cycles checked, %0d mismatches",
                  tests_run, failed_tests, cycles_checked, mismatch_count);
         report_done = 1'b1;
      end
   end

endmodule

//--- tb_tree_arbiter.sv
`timescale 1ns/1ps

// testbench for the two-level round-robin arbiter
// vectors come from tree_arbiter_tests.txt, four hex words per cycle
module tb_tree_arbiter
   import arb_pkg::*;
();

   localparam int MAX_VEC      = 64;   // vectors the memory can hold
   localparam int RESET_LIMIT  = 20;   // cycles to wait for reset release
   localparam int REPORT_LIMIT = 10;   // cycles to wait for the summary

   logic     clk;
   logic     rst_n;
   req_vec_t request;
   req_vec_t grant;
   logic     any_grant;

   // expected values handed to the checker
   req_vec_t exp_grant;
   logic     exp_any;
   int       test_num;
   logic     check_en;
   logic     end_run;

   int       mismatch_count;
   int       failed_tests;
   logic     report_done;

   logic [31:0] vec_mem [0:4*MAX_VEC-1];   // test, request, grant, any_grant
   int          n_vec;

   tree_arbiter i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .request   (request),
      .grant     (grant),
      .any_grant (any_grant)
   );

   tree_arbiter_checker i_check (
      .clk            (clk),
      .rst_n          (rst_n),
      .grant          (grant),
      .any_grant      (any_grant),
      .exp_grant      (exp_grant),
      .exp_any        (exp_any),
      .test_num       (test_num),
      .check_en       (check_en),
      .end_run        (end_run),
      .mismatch_count (mismatch_count),
      .failed_tests   (failed_tests),
      .report_done    (report_done)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;   // 100 ns period

   // reset low for two cycles, released on a falling edge
   initial begin : reset_gen
      rst_n = 1'b0;
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
   end

   initial begin : stimulus
      int i;
      int wait_cycles;
      request   = '0;
      exp_grant = '0;
      exp_any   = 1'b0;
      test_num  = 0;
      check_en  = 1'b0;
      end_run   = 1'b0;

      $readmemh("tree_arbiter_tests.txt", vec_mem);
      n_vec = 0;
      while (n_vec < MAX_VEC && !$isunknown(vec_mem[4*n_vec])
             && vec_mem[4*n_vec] != '0) begin
         n_vec++;   // test numbers start at 1, unfilled reads as X or 0
      end

      wait_cycles = 0;
      while (!rst_n && wait_cycles < RESET_LIMIT) begin
         @(posedge clk);
         wait_cycles++;
      end

      if (n_vec == 0) begin
         $display("no test vectors found in tree_arbiter_tests.txt");
         $display("TESTS FAILED");
      end else if (!rst_n) begin
         $display("reset was not released within %0d cycles", RESET_LIMIT);
         $display("TESTS FAILED");
      end else begin
         i = 0;
         while (i < n_vec && i < MAX_VEC) begin
            @(negedge clk);
            test_num  = int'(vec_mem[4*i]);
            request   = req_vec_t'(vec_mem[4*i+1]);
            exp_grant = req_vec_t'(vec_mem[4*i+2]);
            exp_any   = vec_mem[4*i+3][0];
            check_en  = 1'b1;
            i++;
         end

         @(negedge clk);
         request  = '0;
         check_en = 1'b0;
         end_run  = 1'b1;

         wait_cycles = 0;
         while (!report_done && wait_cycles < REPORT_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
         end

         if (!report_done) begin
            $display("checker gave no summary within %0d cycles", REPORT_LIMIT);
            $display("TESTS FAILED");
         end else if (mismatch_count == 0 && failed_tests == 0) begin
            $display("TESTS PASSED");
         end else begin
            $display("TESTS FAILED");
         end
      end
      $finish;
   end

endmodule

//--- tree_arbiter_tests.txt
// columns: test number, request, expected grant, expected any_grant (all hex)
// one line per clock cycle, tests run in file order from reset
01 0000 0000 0
01 0000 0000 0
02 1111 0001 1
02 1111 0010 1
02 1111 0100 1
02 1111 1000 1
02 1111 0001 1
03 000f 0002 1
03 000f 0004 1
03 000f 0008 1
03 000f 0001 1
03 000f 0002 1
03 000f 0004 1
04 0ff0 0020 1
04 0ff0 0200 1
04 0ff0 0040 1
04 0ff0 0400 1
05 8000 8000 1
05 0001 0001 1
05 0040 0040 1
05 0100 0100 1
05 0010 0010 1

//--- all.f
arb_pkg.sv
arb_if.sv
rr_group_arbiter.sv
rr_thermo_arbiter.sv
tree_arbiter.sv
tree_arbiter_checker.sv
tb_tree_arbiter.sv

//--- Bender.yml
package:
  name: tree_arbiter

dependencies: {}

sources:
  - arb_pkg.sv
  - arb_if.sv
  - rr_group_arbiter.sv
  - rr_thermo_arbiter.sv
  - tree_arbiter.sv
  - target: test
    files:
      - tree_arbiter_checker.sv
      - tb_tree_arbiter.sv
